// ==== az_acq_top.f ====
rtl/az_pkg.sv
rtl/az_sequencer.sv
rtl/adc_conv_ctl.sv
rtl/az_acq_top.sv
bench/az_acq_checker.sv
bench/az_acq_tb.sv

// ==== bench/az_acq_checker.sv ====
// port level checks on az_acq_top, attached with bind
// assumes arm_i holds each level for at least 4 clk cycles
// fail_count holds the number of failed assertions
`timescale 1ns/1ps

module az_acq_checker #(
  parameter logic [az_pkg::CNT_W-1:0]   PRECHARGE_CNT = 24'd5,
  parameter logic [az_pkg::CNT_W-1:0]   APERTURE_CNT  = 24'd12,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_HI      = 4'h1,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_LO      = 4'h6
) (
  input logic                        clk,
  input logic                        rst_i,
  input logic                        arm_i,
  input logic                        adc_trig_o,
  input logic                        adc_valid_o,
  input logic                        sw_pc_o,
  input logic [az_pkg::AZMUX_W-1:0]  azmux_o,
  input logic [az_pkg::STATUS_W-1:0] status_o,
  input logic                        led_o,
  input logic [1:0]                  monitor_o
);

  // arm age past which any conversion left over from a restart is done
  localparam int SETTLED = int'(APERTURE_CNT) + 6;
  // arm age between first and second sample after a restart
  localparam int SECOND  = 4 * (int'(PRECHARGE_CNT) + 2) + int'(APERTURE_CNT) + 8;

  int unsigned fail_count = 0;
  int          arm_age;
  int          low_len;
  logic        arm_q;

  //////////////////////////////
  // helper counters

  always_ff @(posedge clk)
  begin
    arm_q <= arm_i;
    // cycles since arm_i last changed, saturating
    if (rst_i || arm_i != arm_q)
      arm_age <= 0;
    else if (arm_age <= SECOND)
      arm_age <= arm_age + 1;
    // length of the current valid low stretch
    if (rst_i || adc_valid_o)
      low_len <= 0;
    else
      low_len <= low_len + 1;
  end

  //////////////////////////////
  // protection, trig/valid, alternation

  mux_on_boot: assert property (@(posedge clk) disable iff (rst_i)
    $changed(azmux_o) |-> $past(sw_pc_o) == az_pkg::SW_PC_BOOT)
    else begin $error("azmux_o moved while sw_pc_o on signal"); fail_count++; end

  lo_on_boot: assert property (@(posedge clk) disable iff (rst_i)
    azmux_o == AZMUX_LO |-> sw_pc_o == az_pkg::SW_PC_BOOT)
    else begin $error("sw_pc_o on signal with azmux_o at lo"); fail_count++; end

  trig_held: assert property (@(posedge clk) disable iff (rst_i || !arm_i)
    adc_trig_o && adc_valid_o |=> adc_trig_o)
    else begin $error("adc_trig_o dropped before valid went low"); fail_count++; end

  trig_release: assert property (@(posedge clk) disable iff (rst_i)
    adc_trig_o && !adc_valid_o |=> !adc_trig_o)
    else begin $error("adc_trig_o held after valid went low"); fail_count++; end

  aperture_len: assert property (@(posedge clk) disable iff (rst_i)
    $rose(adc_valid_o) |-> low_len == int'(APERTURE_CNT) + 1)
    else begin $error("adc_valid_o low for %0d cycles", low_len); fail_count++; end

  status_by_mux: assert property (@(posedge clk) disable iff (rst_i)
    $rose(adc_valid_o) && arm_i && arm_age > SETTLED |=>
      (azmux_o == AZMUX_HI && status_o == 3'b001) || (azmux_o == AZMUX_LO && status_o == '0))
    else begin $error("status_o does not match the sampled input"); fail_count++; end

  status_toggles: assert property (@(posedge clk) disable iff (rst_i)
    $rose(adc_valid_o) && arm_i && arm_age > SECOND |=> status_o != $past(status_o))
    else begin $error("two samples in a row of the same kind"); fail_count++; end

  // led is lit for the hi conversion only, trig drops as each conversion starts
  led_by_half: assert property (@(posedge clk) disable iff (rst_i)
    $fell(adc_trig_o) && arm_i |-> led_o == (azmux_o == AZMUX_HI))
    else begin $error("led_o does not mark the hi conversion"); fail_count++; end

  // scope lines
  monitor_lines: assert property (@(posedge clk) disable iff (rst_i)
    monitor_o == {azmux_o == AZMUX_HI, adc_trig_o})
    else begin $error("monitor_o does not follow trig and mux"); fail_count++; end

endmodule

// ==== bench/az_acq_tb.sv ====
// testbench for az_acq_top: reset state, start latency and park per arm pulse
// trig/valid, protection and status rules are checked by the bound az_acq_checker
`timescale 1ns/1ps

module az_acq_tb;

  localparam logic [az_pkg::CNT_W-1:0]   PRE    = 24'd5;
  localparam logic [az_pkg::CNT_W-1:0]   APER   = 24'd12;
  localparam logic [az_pkg::AZMUX_W-1:0] MUX_HI = 4'h1;
  localparam logic [az_pkg::AZMUX_W-1:0] MUX_LO = 4'h6;
  localparam int PULSES = 12;

  logic                        clk = 1'b0;
  logic                        rst_i;
  logic                        arm_i;
  logic                        adc_trig_o;
  logic                        adc_valid_o;
  logic                        sw_pc_o;
  logic [az_pkg::AZMUX_W-1:0]  azmux_o;
  logic [az_pkg::STATUS_W-1:0] status_o;
  logic                        led_o;
  logic [1:0]                  monitor_o;

  int          errors       = 0;
  int          tests        = 0;
  int          failed_tests = 0;
  int          limit_cycles = 0;
  logic [31:0] lcg_state    = 32'h5401_87fa;
  int          hi_len [PULSES];
  int          lo_len [PULSES];

  always #20 clk = ~clk;

  az_acq_top #(
    .PRECHARGE_CNT (PRE),
    .APERTURE_CNT  (APER),
    .AZMUX_HI      (MUX_HI),
    .AZMUX_LO      (MUX_LO)
  ) uut (
    .clk         (clk),
    .rst_i       (rst_i),
    .arm_i       (arm_i),
    .adc_trig_o  (adc_trig_o),
    .adc_valid_o (adc_valid_o),
    .sw_pc_o     (sw_pc_o),
    .azmux_o     (azmux_o),
    .status_o    (status_o),
    .led_o       (led_o),
    .monitor_o   (monitor_o)
  );

  bind az_acq_top az_acq_checker #(
    .PRECHARGE_CNT (PRECHARGE_CNT),
    .APERTURE_CNT  (APERTURE_CNT),
    .AZMUX_HI      (AZMUX_HI),
    .AZMUX_LO      (AZMUX_LO)
  ) u_chk (
    .clk         (clk),
    .rst_i       (rst_i),
    .arm_i       (arm_i),
    .adc_trig_o  (adc_trig_o),
    .adc_valid_o (adc_valid_o),
    .sw_pc_o     (sw_pc_o),
    .azmux_o     (azmux_o),
    .status_o    (status_o),
    .led_o       (led_o),
    .monitor_o   (monitor_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // bench errors plus checker assertion failures
  function automatic int fault_count();
    return errors + int'(uut.u_chk.fail_count);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    tests++;
    if (fault_count() == mark)
      $display("test %s: ok", name);
    else
    begin
      failed_tests++;
      $display("test %s: failed", name);
    end
  endtask

  //////////////////////////////
  // arm phases

  // arm high for len cycles, timing the mux move when it starts from lo
  task automatic hold_armed(input int len);
    int   cyc;
    logic moved;
    logic from_lo;
    from_lo = (azmux_o == MUX_LO);
    moved   = 1'b0;
    cyc     = 0;
    arm_i   = 1'b1;
    repeat (len)
    begin
      @(negedge clk);
      cyc++;
      if (from_lo && !moved && azmux_o == MUX_HI)
      begin
        moved = 1'b1;
        // two sync register cycles, then PRE+5 to the mux move
        check_val("start latency", cyc, int'(PRE) + 7);
      end
    end
    if (from_lo && !moved && len >= int'(PRE) + 7)
    begin
      $display("ERROR at time %0t: azmux_o never moved to hi after arm rose", $time);
      errors++;
    end
  endtask

  // arm low: park within three cycles, then mux and status frozen
  task automatic hold_parked(input int len);
    logic [az_pkg::AZMUX_W-1:0]  mux_held;
    logic [az_pkg::STATUS_W-1:0] status_held;
    arm_i = 1'b0;
    repeat (3) @(negedge clk);
    check_val("adc_trig_o", adc_trig_o, 1'b0);
    check_val("sw_pc_o", sw_pc_o, az_pkg::SW_PC_BOOT);
    mux_held    = azmux_o;
    status_held = status_o;
    repeat (len - 3)
    begin
      @(negedge clk);
      check_val("azmux_o", azmux_o, mux_held);
      check_val("status_o", status_o, status_held);
    end
  endtask

  //////////////////////////////
  // main sequence

  initial
  begin
    int mark;
    int total;
    rst_i = 1'b1;
    arm_i = 1'b0;
    total = 0;
    // every third pulse spans several hi/lo cycles, the rest cut phases short
    for (int i = 0; i < PULSES; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      if (i % 3 == 0)
        hi_len[i] = 150 + (int'(lcg_state >> 16) % 150);
      else
        hi_len[i] = 4 + (int'(lcg_state >> 16) % 60);
      lcg_state = lcg_next(lcg_state);
      lo_len[i] = 4 + (int'(lcg_state >> 16) % 20);
      total += hi_len[i] + lo_len[i];
    end
    limit_cycles = total + 1000;

    repeat (4) @(negedge clk);
    rst_i = 1'b0;
    mark = fault_count();
    repeat (2) @(negedge clk);
    check_val("adc_trig_o", adc_trig_o, 1'b0);
    check_val("sw_pc_o", sw_pc_o, az_pkg::SW_PC_BOOT);
    check_val("azmux_o", azmux_o, MUX_LO);
    check_val("status_o", status_o, 0);
    check_val("led_o", led_o, 1'b0);
    check_val("adc_valid_o", adc_valid_o, 1'b1);
    finish_test("reset state", mark);

    for (int i = 0; i < PULSES; i++)
    begin
      mark = fault_count();
      hold_armed(hi_len[i]);
      hold_parked(lo_len[i]);
      finish_test($sformatf("arm pulse %0d (hi %0d, lo %0d)", i, hi_len[i], lo_len[i]), mark);
    end

    $display("tests %0d, passed %0d, failed %0d, bench errors %0d, assertion failures %0d",
             tests, tests - failed_tests, failed_tests, errors, uut.u_chk.fail_count);
    if (failed_tests == 0 && fault_count() == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog sized from the planned arm lengths
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run did not end within %0d cycles", limit_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== rtl/adc_conv_ctl.sv ====
// stand-in for the integrating ADC start/done handshake, no result data
// valid is low for APERTURE_CNT+1 cycles, timed from the drop, if trig falls within that
// APERTURE_CNT must be at least 2
`timescale 1ns/1ps

module adc_conv_ctl #(
  parameter logic [az_pkg::CNT_W-1:0] APERTURE_CNT = 24'd360000
) (
  input  logic clk,
  input  logic rst_i,
  input  logic trig_i,
  output logic valid_o
);

  az_pkg::adc_state_t        state;
  logic [az_pkg::CNT_W-1:0]  aper_cnt;

  //////////////////////////////
  // trig/valid exchange

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      // idle with last result counted as done
      state    <= az_pkg::C_DONE;
      valid_o  <= 1'b1;
      aper_cnt <= '0;
    end
    else
    begin
      case (state)
        // valid high until a new trigger arrives
        az_pkg::C_DONE:
          if (trig_i)
          begin
            valid_o  <= 1'b0;
            aper_cnt <= APERTURE_CNT;
            state    <= az_pkg::C_IDLE;
          end

        // acked, waiting for trig to go away
        // aperture already running so a late trig release does not stretch it
        az_pkg::C_IDLE:
        begin
          if (aper_cnt != '0)
            aper_cnt <= aper_cnt - 1'b1;
          if (!trig_i)
            state <= az_pkg::C_BUSY;
        end

        // trig ignored here, conversion cannot be restarted or cut short
        az_pkg::C_BUSY:
          if (aper_cnt == '0)
          begin
            valid_o <= 1'b1;
            state   <= az_pkg::C_DONE;
          end
          else
            aper_cnt <= aper_cnt - 1'b1;

        default:
        begin
          valid_o <= 1'b1;
          state   <= az_pkg::C_DONE;
        end
      endcase
    end
  end

endmodule

// ==== rtl/az_acq_top.sv ====
// auto-zero acquisition core, sequencer plus conversion controller
// all counts are in clk cycles and fixed per board through the parameters
// trig and valid come out as ports for observation only
`timescale 1ns/1ps

module az_acq_top #(
  // defaults assume a 36 MHz clk: 500 us settle, 10 ms aperture
  parameter logic [az_pkg::CNT_W-1:0]   PRECHARGE_CNT = 24'd18000,
  parameter logic [az_pkg::CNT_W-1:0]   APERTURE_CNT  = 24'd360000,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_HI      = 4'h1,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_LO      = 4'h6
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        arm_i,
  output logic                        adc_trig_o,
  output logic                        adc_valid_o,
  output logic                        sw_pc_o,
  output logic [az_pkg::AZMUX_W-1:0]  azmux_o,
  output logic [az_pkg::STATUS_W-1:0] status_o,
  output logic                        led_o,
  output logic [1:0]                  monitor_o
);

  //////////////////////////////
  // hi/lo sequencer

  az_sequencer #(
    .PRECHARGE_CNT (PRECHARGE_CNT),
    .AZMUX_HI      (AZMUX_HI),
    .AZMUX_LO      (AZMUX_LO)
  ) u_seq (
    .clk         (clk),
    .rst_i       (rst_i),
    .arm_i       (arm_i),
    .adc_valid_i (adc_valid_o),
    .adc_trig_o  (adc_trig_o),
    .sw_pc_o     (sw_pc_o),
    .azmux_o     (azmux_o),
    .status_o    (status_o),
    .led_o       (led_o),
    .monitor_o   (monitor_o)
  );

  //////////////////////////////
  // conversion controller, answers the sequencer trigger

  adc_conv_ctl #(
    .APERTURE_CNT (APERTURE_CNT)
  ) u_adc (
    .clk     (clk),
    .rst_i   (rst_i),
    .trig_i  (adc_trig_o),
    .valid_o (adc_valid_o)
  );

endmodule

// ==== rtl/az_pkg.sv ====
// shared constants and state encodings for the auto-zero acquisition core
// sequencer state codes follow the legacy numbering so existing probes still decode
// status bit 1 (4-wire) and bit 2 are reserved and stay zero in this block
package az_pkg;

  // widths of the mux code, status word and all phase/aperture counters
  parameter int AZMUX_W       = 4;
  parameter int STATUS_W      = 3;
  parameter int STATUS_HI_BIT = 0;
  parameter int CNT_W         = 24;

  // precharge switch drive levels
  parameter logic SW_PC_BOOT   = 1'b0;
  parameter logic SW_PC_SIGNAL = 1'b1;

  //////////////////////////////
  // auto-zero sequencer states
  typedef enum logic [6:0] {
    S_START        = 7'd0,
    S_HI_BOOT      = 7'd1,
    S_HI_BOOT_WAIT = 7'd15,
    S_HI_MUX       = 7'd2,
    S_HI_MUX_WAIT  = 7'd25,
    S_HI_SIG       = 7'd3,
    S_HI_SIG_WAIT  = 7'd33,
    S_HI_ACK       = 7'd34,
    S_HI_CONV      = 7'd35,
    S_LO_BOOT      = 7'd4,
    S_LO_BOOT_WAIT = 7'd45,
    S_LO_MUX       = 7'd5,
    S_LO_MUX_WAIT  = 7'd52,
    S_LO_ACK       = 7'd53,
    S_LO_CONV      = 7'd55,
    S_PARK         = 7'd60
  } az_state_t;

  // conversion controller states
  typedef enum logic [1:0] {
    C_IDLE = 2'd0,
    C_BUSY = 2'd1,
    C_DONE = 2'd2
  } adc_state_t;

endpackage

// ==== rtl/az_sequencer.sv ====
// auto-zero hi/lo acquisition sequencer
// arm_i is asynchronous; both its edges act one cycle after the second sync register
// the hi input mux is outside this block, hi is reached through the precharge switch
// settle steps last PRECHARGE_CNT+2 cycles, conversions as long as the ADC takes
`timescale 1ns/1ps

module az_sequencer #(
  parameter logic [az_pkg::CNT_W-1:0]   PRECHARGE_CNT = 24'd18000,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_HI      = 4'h1,
  parameter logic [az_pkg::AZMUX_W-1:0] AZMUX_LO      = 4'h6
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        arm_i,
  input  logic                        adc_valid_i,
  output logic                        adc_trig_o,
  output logic                        sw_pc_o,
  output logic [az_pkg::AZMUX_W-1:0]  azmux_o,
  output logic [az_pkg::STATUS_W-1:0] status_o,
  output logic                        led_o,
  output logic [1:0]                  monitor_o
);

  // status word after a hi sample, all other bits zero
  localparam logic [az_pkg::STATUS_W-1:0] STATUS_HI =
    {{(az_pkg::STATUS_W-1){1'b0}}, 1'b1} << az_pkg::STATUS_HI_BIT;

  az_pkg::az_state_t          state;
  logic [az_pkg::CNT_W-1:0]   phase_cnt;

  // arm synchronizer plus one delay stage for the edge detect
  logic                       arm_meta;
  logic                       arm_sync;
  logic                       arm_sync_q;
  logic                       arm_rise;
  logic                       arm_fall;

  //////////////////////////////
  // arm input sampling

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      arm_meta   <= 1'b0;
      arm_sync   <= 1'b0;
      arm_sync_q <= 1'b0;
    end
    else
    begin
      arm_meta   <= arm_i;
      arm_sync   <= arm_meta;
      arm_sync_q <= arm_sync;
    end
  end

  assign arm_rise = arm_sync & ~arm_sync_q;
  assign arm_fall = ~arm_sync & arm_sync_q;

  // scope lines: trigger, and mux sitting on the hi code
  assign monitor_o[0] = adc_trig_o;
  assign monitor_o[1] = (azmux_o == AZMUX_HI);

  //////////////////////////////
  // hi/lo cycle

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state      <= az_pkg::S_PARK;
      phase_cnt  <= '0;
      adc_trig_o <= 1'b0;
      sw_pc_o    <= az_pkg::SW_PC_BOOT;
      azmux_o    <= AZMUX_LO;
      status_o   <= '0;
      led_o      <= 1'b0;
    end
    else
    begin
      // one shared countdown, parked at zero between phases
      if (phase_cnt != '0)
        phase_cnt <= phase_cnt - 1'b1;

      if (arm_rise)
        // restart from any state, even mid-conversion
        state <= az_pkg::S_START;
      else if (arm_fall)
      begin
        // park: drop trigger and protect the signal at once, mux stays put
        state      <= az_pkg::S_PARK;
        adc_trig_o <= 1'b0;
        sw_pc_o    <= az_pkg::SW_PC_BOOT;
        led_o      <= 1'b0;
      end
      else
      begin
        case (state)
          az_pkg::S_PARK:
            ;

          // single cycle entry, handy as a marker on the trigger line
          az_pkg::S_START:
          begin
            adc_trig_o <= 1'b0;
            led_o      <= 1'b0;
            state      <= az_pkg::S_HI_BOOT;
          end

          // precharge switch to boot before the mux moves
          az_pkg::S_HI_BOOT:
          begin
            sw_pc_o   <= az_pkg::SW_PC_BOOT;
            phase_cnt <= PRECHARGE_CNT;
            state     <= az_pkg::S_HI_BOOT_WAIT;
          end
          az_pkg::S_HI_BOOT_WAIT:
            if (phase_cnt == '0)
              state <= az_pkg::S_HI_MUX;

          // mux to hi, signal still shielded by the boot level
          az_pkg::S_HI_MUX:
          begin
            azmux_o   <= AZMUX_HI;
            phase_cnt <= PRECHARGE_CNT;
            state     <= az_pkg::S_HI_MUX_WAIT;
          end
          az_pkg::S_HI_MUX_WAIT:
            if (phase_cnt == '0)
              state <= az_pkg::S_HI_SIG;

          // release to signal, let the sig/boot offset settle
          az_pkg::S_HI_SIG:
          begin
            sw_pc_o   <= az_pkg::SW_PC_SIGNAL;
            phase_cnt <= PRECHARGE_CNT;
            state     <= az_pkg::S_HI_SIG_WAIT;
          end
          az_pkg::S_HI_SIG_WAIT:
            if (phase_cnt == '0)
            begin
              adc_trig_o <= 1'b1;
              state      <= az_pkg::S_HI_ACK;
            end

          // adc acks by dropping valid
          az_pkg::S_HI_ACK:
            if (!adc_valid_i)
            begin
              adc_trig_o <= 1'b0;
              led_o      <= 1'b1;
              state      <= az_pkg::S_HI_CONV;
            end

          // status only moves once the sample is done, leaves a full cycle to read it
          az_pkg::S_HI_CONV:
            if (adc_valid_i)
            begin
              status_o <= STATUS_HI;
              state    <= az_pkg::S_LO_BOOT;
            end

          //////////////////////////////
          // lo half, switch stays on boot throughout

          az_pkg::S_LO_BOOT:
          begin
            sw_pc_o   <= az_pkg::SW_PC_BOOT;
            phase_cnt <= PRECHARGE_CNT;
            state     <= az_pkg::S_LO_BOOT_WAIT;
          end
          az_pkg::S_LO_BOOT_WAIT:
            if (phase_cnt == '0)
              state <= az_pkg::S_LO_MUX;

          az_pkg::S_LO_MUX:
          begin
            azmux_o   <= AZMUX_LO;
            phase_cnt <= PRECHARGE_CNT;
            state     <= az_pkg::S_LO_MUX_WAIT;
          end
          az_pkg::S_LO_MUX_WAIT:
            if (phase_cnt == '0)
            begin
              adc_trig_o <= 1'b1;
              state      <= az_pkg::S_LO_ACK;
            end

          az_pkg::S_LO_ACK:
            if (!adc_valid_i)
            begin
              adc_trig_o <= 1'b0;
              led_o      <= 1'b0;
              state      <= az_pkg::S_LO_CONV;
            end

          // lo sample done, go round again through boot
          az_pkg::S_LO_CONV:
            if (adc_valid_i)
            begin
              status_o <= '0;
              state    <= az_pkg::S_HI_BOOT;
            end

          default:
            state <= az_pkg::S_PARK;
        endcase
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the az_acq_top testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module az_acq_tb \
  -f az_acq_top.f -o az_acq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

# assertion failures must not stop the run before the result line
./obj_dir/az_acq_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0
